//--- list.f
verilog/mmu_pkg.sv
verilog/sv32_tlb.sv
verilog/sv32_ptw.sv
verilog/mmu.sv
verilog/pt_ram.sv
verilog/mmu_top.sv
test/tb_mmu.sv

//--- Makefile
TOP = tb_mmu

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --top-module $(TOP) -f list.f -Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_mmu.sv
module tb_mmu;

    timeunit 1ns;
    timeprecision 100ps;

    import mmu_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int N_BARE      = 16;
    localparam int N_PAGE      = 12;  // Each page requested twice
    localparam int N_SUPER     = 12;
    localparam int N_PERM      = 24;
    localparam int N_BAD       = 8;
    localparam int N_FLUSH     = 7;
    localparam int N_REQ       = N_BARE + 2 * N_PAGE + N_SUPER + N_PERM + N_BAD + N_FLUSH;
    localparam int WAIT_LIMIT  = 20;
    localparam int WATCHDOG_NS = N_REQ * 30 * CLK_PERIOD + 1000;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    trans_req_t  req;
    logic [31:0] satp;
    logic        vm_enable;
    logic        tlb_flush;
    logic        flush_one;
    logic [31:0] flush_addr;
    logic        pt_wr_en;
    logic [11:0] pt_wr_addr;
    pte_t        pt_wr_data;
    trans_rsp_t  rsp;

    pte_t        mirror [4096];     // Copy of the page table memory
    logic [15:0] lfsr_state = 16'd54;
    int          errors     = 0;
    int          timeouts   = 0;
    int          checks     = 0;

    mmu_top #(
        .TLB_ENTRIES (8),
        .PT_WORDS    (4096)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .satp       (satp),
        .vm_enable  (vm_enable),
        .tlb_flush  (tlb_flush),
        .flush_one  (flush_one),
        .flush_addr (flush_addr),
        .pt_wr_en   (pt_wr_en),
        .pt_wr_addr (pt_wr_addr),
        .pt_wr_data (pt_wr_data),
        .rsp        (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic priv_t pick_priv();
        logic [1:0] sel;
        sel = 2'(rand_bits(2));
        case (sel)
            2'd0:    return PRIV_U;
            2'd1:    return PRIV_S;
            default: return PRIV_M;
        endcase
    endfunction

    // Memory sees byte address bits 13:2, i.e. PPN[1:0] and the level index
    function automatic logic [11:0] pt_index(input logic [19:0] ppn, input logic [9:0] idx);
        return {ppn[1:0], idx};
    endfunction

    function automatic logic [1:0] table_of(input logic [9:0] vpn1);
        return 2'(1 + vpn1 % 3);  // Level-0 tables 1 to 3, root is table 0
    endfunction

    function automatic logic [11:0] root_index(input logic [31:0] vaddr);
        return pt_index(satp[19:0], vaddr[31:22]);
    endfunction

    function automatic logic [11:0] leaf_index(input logic [31:0] vaddr);
        return pt_index({18'd0, table_of(vaddr[31:22])}, vaddr[21:12]);
    endfunction

    function automatic pte_t make_pte(input logic [19:0] ppn, input logic u, input logic x,
                                      input logic w, input logic r, input logic v);
        pte_t p;
        p      = '0;
        p.ppn1 = {2'b00, ppn[19:10]};
        p.ppn0 = ppn[9:0];
        p.u    = u;
        p.x    = x;
        p.w    = w;
        p.r    = r;
        p.v    = v;
        return p;
    endfunction

    function automatic logic [19:0] pte_ppn(input pte_t p);
        return {p.ppn1[9:0], p.ppn0};
    endfunction

    function automatic logic pte_invalid(input pte_t p);
        return !p.v || (p.w && !p.r);
    endfunction

    function automatic logic pte_pointer(input pte_t p);
        return !(p.r || p.w || p.x);
    endfunction

    // Reference walk over the mirrored tables
    function automatic trans_rsp_t model_xlate(input trans_req_t r);
        trans_rsp_t  e;
        pte_t        p;
        logic        is_super;
        logic        allowed;
        logic [19:0] ppn;
        e = '0;
        if (!vm_enable) begin
            e.paddr = r.vaddr;
            e.done  = 1'b1;
            return e;
        end
        p        = mirror[root_index(r.vaddr)];
        is_super = 1'b1;
        if (!pte_invalid(p) && pte_pointer(p)) begin
            p        = mirror[pt_index(pte_ppn(p), r.vaddr[21:12])];
            is_super = 1'b0;
            if (pte_pointer(p)) begin
                e.page_fault = 1'b1;  // No third level
                return e;
            end
        end
        if (pte_invalid(p) || (is_super && p.ppn0 != '0)) begin
            e.page_fault = 1'b1;
            return e;
        end
        ppn = pte_ppn(p);
        case (r.priv)
            PRIV_M:  allowed = 1'b1;
            PRIV_S:  allowed = !p.u;
            default: allowed = p.u;
        endcase
        if (r.write) begin
            allowed = allowed && p.w;
        end else begin
            allowed = allowed && p.r;
        end
        e.paddr        = is_super ? {ppn[19:10], r.vaddr[21:0]} : {ppn, r.vaddr[11:0]};
        e.done         = allowed;
        e.access_fault = !allowed;
        return e;
    endfunction

    task automatic check_paddr(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: rsp.paddr got %h, expected %h", $realtime, what, got, exp);
        end
    endtask

    task automatic check_rsp(input trans_rsp_t got, input trans_rsp_t exp, input string what);
        checks++;
        if ({got.done, got.page_fault, got.access_fault}
                !== {exp.done, exp.page_fault, exp.access_fault}) begin
            errors++;
            $display("[ERROR] %0t %s: rsp.{done,page_fault,access_fault} got %b%b%b, expected %b%b%b",
                     $realtime, what, got.done, got.page_fault, got.access_fault,
                     exp.done, exp.page_fault, exp.access_fault);
        end else if (exp.done) begin
            check_paddr(got.paddr, exp.paddr, what);
        end
    endtask

    task automatic write_pte(input logic [11:0] idx, input pte_t p);
        pt_wr_en    = 1'b1;
        pt_wr_addr  = idx;
        pt_wr_data  = p;
        mirror[idx] = p;
        @(posedge clk);
        #2;
        pt_wr_en    = 1'b0;
    endtask

    task automatic map_page(input logic [31:0] vaddr, input pte_t leaf);
        logic [19:0] ptr_ppn;
        ptr_ppn = {18'(rand_bits(18)), table_of(vaddr[31:22])};  // Upper bits alias away
        write_pte(root_index(vaddr), make_pte(ptr_ppn, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
        write_pte(leaf_index(vaddr), leaf);
    endtask

    task automatic flush_tlb(input logic one, input logic [31:0] addr);
        tlb_flush  = 1'b1;
        flush_one  = one;
        flush_addr = addr;
        @(posedge clk);
        #2;
        tlb_flush  = 1'b0;
        flush_one  = 1'b0;
    endtask

    // Hold the request until any result strobe, sampled mid-cycle
    task automatic issue_request(input trans_req_t r, input string what,
                                 output trans_rsp_t got, output bit seen);
        seen      = 1'b0;
        got       = '0;
        req       = r;
        req_valid = 1'b1;
        for (int cyc = 0; cyc < WAIT_LIMIT && !seen; cyc++) begin
            @(negedge clk);
            if (rsp.done || rsp.page_fault || rsp.access_fault) begin
                got  = rsp;
                seen = 1'b1;
            end
            @(posedge clk);
            #2;
        end
        req_valid = 1'b0;
        @(posedge clk);  // Idle cycle between requests
        #2;
        if (!seen) begin
            timeouts++;
            $display("%0t %s: no result for vaddr %h within %0d cycles",
                     $realtime, what, r.vaddr, WAIT_LIMIT);
        end
    endtask

    task automatic request_expect(input trans_req_t r, input trans_rsp_t exp, input string what);
        trans_rsp_t got;
        bit         seen;
        issue_request(r, what, got, seen);
        if (seen) begin
            check_rsp(got, exp, what);
        end
    endtask

    task automatic translate_and_check(input trans_req_t r, input string what);
        request_expect(r, model_xlate(r), what);
    endtask

    task automatic run_bare();
        trans_req_t r;
        vm_enable = 1'b0;
        for (int i = 0; i < N_BARE; i++) begin
            r.vaddr = rand_bits(32);
            r.write = 1'(rand_bits(1));
            r.priv  = pick_priv();
            translate_and_check(r, "bare mode");
        end
        vm_enable = 1'b1;
    endtask

    task automatic run_pages();
        trans_req_t r;
        for (int i = 0; i < N_PAGE; i++) begin
            r.vaddr = rand_bits(32);
            r.write = 1'(rand_bits(1));
            r.priv  = PRIV_U;
            map_page(r.vaddr, make_pte(20'(rand_bits(20)), 1'b1, 1'b0, 1'b1, 1'b1, 1'b1));
            flush_tlb(1'b0, '0);
            translate_and_check(r, "4 KB page miss");
            translate_and_check(r, "4 KB page hit");
        end
    endtask

    task automatic run_superpages();
        trans_req_t  r;
        logic [19:0] ppn;
        for (int i = 0; i < N_SUPER; i++) begin
            r.vaddr = rand_bits(32);
            r.write = 1'(rand_bits(1));
            r.priv  = PRIV_M;
            ppn     = 20'(rand_bits(20));
            if (rand_bits(2) == 0) begin
                ppn[9:0] = ppn[9:0] | 10'h001;  // Misaligned superpage
            end else begin
                ppn[9:0] = '0;
            end
            write_pte(root_index(r.vaddr), make_pte(ppn, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1));
            flush_tlb(1'b0, '0);
            translate_and_check(r, "superpage");
        end
    endtask

    task automatic run_permissions();
        trans_req_t r;
        logic       u;
        logic       rd;
        logic       wr;
        for (int i = 0; i < N_PERM; i++) begin
            r.vaddr = rand_bits(32);
            r.write = 1'(rand_bits(1));
            r.priv  = pick_priv();
            u       = 1'(rand_bits(1));
            rd      = 1'(rand_bits(1));
            wr      = rd && 1'(rand_bits(1));  // x stays set, so always a leaf
            map_page(r.vaddr, make_pte(20'(rand_bits(20)), u, 1'b1, wr, rd, 1'b1));
            flush_tlb(1'b0, '0);
            translate_and_check(r, "permission");
        end
    endtask

    task automatic run_invalid();
        trans_req_t  r;
        logic [19:0] ppn;
        for (int i = 0; i < N_BAD; i++) begin
            r.vaddr  = rand_bits(32);
            r.write  = 1'(rand_bits(1));
            r.priv   = PRIV_M;
            ppn      = 20'(rand_bits(20));
            ppn[9:0] = '0;
            case (i % 4)
                0: write_pte(root_index(r.vaddr), make_pte(ppn, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0));
                1: map_page(r.vaddr, make_pte(ppn, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0));
                2: write_pte(root_index(r.vaddr), make_pte(ppn, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1));
                default: map_page(r.vaddr, make_pte(ppn, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1));
            endcase
            flush_tlb(1'b0, '0);
            translate_and_check(r, "invalid entry");
        end
    endtask

    task automatic run_flushes();
        trans_req_t  ra;
        trans_req_t  rb;
        trans_rsp_t  old_a;
        trans_rsp_t  old_b;
        logic [19:0] ppn_a;
        logic [19:0] ppn_b;
        ra.vaddr         = rand_bits(32);
        ra.write         = 1'b0;
        ra.priv          = PRIV_S;
        rb               = ra;
        rb.vaddr[31:22]  = ra.vaddr[31:22] ^ 10'h155;  // Unrelated page
        rb.vaddr[21:12]  = ra.vaddr[21:12] ^ 10'h2aa;  // Own level-0 slot
        ppn_a            = 20'(rand_bits(20));
        ppn_b            = 20'(rand_bits(20));
        map_page(ra.vaddr, make_pte(ppn_a, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1));
        map_page(rb.vaddr, make_pte(ppn_b, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1));
        flush_tlb(1'b0, '0);
        translate_and_check(ra, "page A before remap");
        translate_and_check(rb, "page B before remap");
        old_a = model_xlate(ra);
        old_b = model_xlate(rb);
        // Remap both pages behind the TLB's back
        write_pte(leaf_index(ra.vaddr), make_pte(ppn_a ^ 20'h80421, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1));
        write_pte(leaf_index(rb.vaddr), make_pte(ppn_b ^ 20'h13579, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1));
        request_expect(ra, old_a, "page A stale before flush");
        flush_tlb(1'b1, ra.vaddr);
        translate_and_check(ra, "page A after per-address flush");
        request_expect(rb, old_b, "page B kept across per-address flush");
        flush_tlb(1'b0, '0);
        translate_and_check(rb, "page B after full flush");
        translate_and_check(ra, "page A after full flush");
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        satp       = 32'h8000_0124;  // Root PPN in table 0
        vm_enable  = 1'b0;
        tlb_flush  = 1'b0;
        flush_one  = 1'b0;
        flush_addr = '0;
        pt_wr_en   = 1'b0;
        pt_wr_addr = '0;
        pt_wr_data = '0;
        for (int i = 0; i < 4096; i++) begin
            mirror[i] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(posedge clk);
        #2;

        run_bare();
        run_pages();
        run_superpages();
        run_permissions();
        run_invalid();
        run_flushes();

        $display("Finished: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/mmu_top.sv
module mmu_top #(
    parameter int TLB_ENTRIES = 8,
    parameter int PT_WORDS    = 4096
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  mmu_pkg::trans_req_t     req,
    input  logic [31:0]             satp,
    input  logic                    vm_enable,
    input  logic                    tlb_flush,
    input  logic                    flush_one,
    input  logic [31:0]             flush_addr,
    input  logic                    pt_wr_en,
    input  logic [11:0]             pt_wr_addr,
    input  mmu_pkg::pte_t           pt_wr_data,
    output mmu_pkg::trans_rsp_t     rsp
);

    import mmu_pkg::*;

    // Walker read port
    logic        ptw_req;
    logic [31:0] ptw_addr;
    logic        ptw_ready;
    pte_t        ptw_data;

    mmu #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_mmu (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .satp       (satp),
        .vm_enable  (vm_enable),
        .tlb_flush  (tlb_flush),
        .flush_one  (flush_one),
        .flush_addr (flush_addr),
        .rsp        (rsp),
        .ptw_req    (ptw_req),
        .ptw_addr   (ptw_addr),
        .ptw_ready  (ptw_ready),
        .ptw_data   (ptw_data)
    );

    pt_ram #(
        .PT_WORDS (PT_WORDS)
    ) u_pt_ram (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (pt_wr_en),
        .wr_addr  (pt_wr_addr),
        .wr_data  (pt_wr_data),
        .rd_req   (ptw_req),
        .rd_addr  (ptw_addr),
        .rd_ready (ptw_ready),
        .rd_data  (ptw_data)
    );

endmodule

//--- verilog/pt_ram.sv
module pt_ram #(
    parameter int PT_WORDS = 4096
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            wr_en,
    input  logic [11:0]     wr_addr,
    input  mmu_pkg::pte_t   wr_data,
    input  logic            rd_req,
    input  logic [31:0]     rd_addr,
    output logic            rd_ready,
    output mmu_pkg::pte_t   rd_data
);

    import mmu_pkg::*;

    localparam int AW = $clog2(PT_WORDS);

    pte_t mem [PT_WORDS];

    // Word index from byte address, upper bits alias
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[AW-1:0]] <= wr_data;
        end
        if (rd_req) begin
            rd_data <= mem[rd_addr[AW+1:2]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ready <= 1'b0;
        end else begin
            rd_ready <= rd_req;  // One-cycle pulse
        end
    end

endmodule

//--- verilog/mmu.sv
module mmu #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  mmu_pkg::trans_req_t     req,
    input  logic [31:0]             satp,
    input  logic                    vm_enable,
    input  logic                    tlb_flush,
    input  logic                    flush_one,
    input  logic [31:0]             flush_addr,
    output mmu_pkg::trans_rsp_t     rsp,
    output logic                    ptw_req,
    output logic [31:0]             ptw_addr,
    input  logic                    ptw_ready,
    input  mmu_pkg::pte_t           ptw_data
);

    import mmu_pkg::*;

    logic       hit;
    tlb_entry_t hit_entry;
    logic       fill;
    tlb_entry_t fill_entry;
    logic       walk_fault;
    logic       priv_ok;
    logic       perm_ok;
    logic       xlate;      // Translated request in flight
    logic [31:0] xlate_paddr;

    sv32_tlb #(
        .TLB_ENTRIES (TLB_ENTRIES)
    ) u_tlb (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_vaddr (req.vaddr),
        .hit          (hit),
        .hit_entry    (hit_entry),
        .fill         (fill),
        .fill_entry   (fill_entry),
        .flush        (tlb_flush),
        .flush_one    (flush_one),
        .flush_addr   (flush_addr)
    );

    sv32_ptw u_ptw (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (xlate && !hit),  // Ignored unless the walker is idle
        .vaddr      (req.vaddr),
        .root_ppn   (satp[PPN_W-1:0]),
        .mem_req    (ptw_req),
        .mem_addr   (ptw_addr),
        .mem_ready  (ptw_ready),
        .mem_data   (ptw_data),
        .fill       (fill),
        .fill_entry (fill_entry),
        .fault      (walk_fault)
    );

    assign xlate = req_valid && vm_enable;

    always_comb begin
        case (req.priv)
            PRIV_M:  priv_ok = 1'b1;
            PRIV_S:  priv_ok = !hit_entry.u;
            default: priv_ok = hit_entry.u;  // User mode
        endcase
        perm_ok = req.write ? hit_entry.w : hit_entry.r;
    end

    // Superpage keeps VPN0 from the request
    assign xlate_paddr = hit_entry.superpage
        ? {hit_entry.ppn[PPN_W-1:VPN_W], req.vaddr[OFFSET_W+VPN_W-1:0]}
        : {hit_entry.ppn, req.vaddr[OFFSET_W-1:0]};

    always_comb begin
        if (!vm_enable) begin
            rsp.paddr        = req.vaddr;
            rsp.done         = req_valid;
            rsp.page_fault   = 1'b0;
            rsp.access_fault = 1'b0;
        end else begin
            rsp.paddr        = hit ? xlate_paddr : '0;
            rsp.done         = xlate && hit && priv_ok && perm_ok;
            rsp.access_fault = xlate && hit && !(priv_ok && perm_ok);
            rsp.page_fault   = xlate && walk_fault;
        end
    end

endmodule

//--- verilog/sv32_ptw.sv
module sv32_ptw (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [31:0]             vaddr,
    input  logic [19:0]             root_ppn,
    output logic                    mem_req,
    output logic [31:0]             mem_addr,
    input  logic                    mem_ready,
    input  mmu_pkg::pte_t           mem_data,
    output logic                    fill,
    output mmu_pkg::tlb_entry_t     fill_entry,
    output logic                    fault
);

    import mmu_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_L1_REQ,
        S_L1_WAIT,
        S_L0_REQ,
        S_L0_WAIT,
        S_DONE
    } state_t;

    state_t           state, state_nxt;
    logic [31:0]      vaddr_q;    // Stable copy for the whole walk
    logic [PPN_W-1:0] base_ppn;   // Table being read at this level
    logic [VPN_W-1:0] vpn_idx;
    logic [PPN_W-1:0] pte_ppn;
    logic             pte_bad;
    logic             pte_ptr;
    logic             leaf;

    // Physical addresses are 32 bits here, top two PPN1 bits dropped
    assign pte_ppn = {mem_data.ppn1[PPN_W-VPN_W-1:0], mem_data.ppn0};
    assign pte_bad = !mem_data.v || (mem_data.w && !mem_data.r);
    assign pte_ptr = !mem_data.r && !mem_data.w && !mem_data.x;

    assign vpn_idx  = (state == S_L0_REQ) ? vaddr_q[OFFSET_W+VPN_W-1:OFFSET_W]
                                          : vaddr_q[31:OFFSET_W+VPN_W];
    assign mem_addr = {base_ppn, vpn_idx, 2'b00};  // 4-byte PTEs
    assign mem_req  = (state == S_L1_REQ) || (state == S_L0_REQ);
    assign fill     = (state == S_DONE);

    always_comb begin
        state_nxt = state;
        fault     = 1'b0;
        leaf      = 1'b0;
        case (state)
            S_IDLE:   if (start) state_nxt = S_L1_REQ;
            S_L1_REQ: state_nxt = S_L1_WAIT;
            S_L1_WAIT: begin
                if (mem_ready) begin
                    if (pte_bad || (!pte_ptr && mem_data.ppn0 != '0)) begin
                        fault     = 1'b1;  // Includes misaligned superpage
                        state_nxt = S_IDLE;
                    end else if (pte_ptr) begin
                        state_nxt = S_L0_REQ;
                    end else begin
                        leaf      = 1'b1;
                        state_nxt = S_DONE;
                    end
                end
            end
            S_L0_REQ: state_nxt = S_L0_WAIT;
            S_L0_WAIT: begin
                if (mem_ready) begin
                    if (pte_bad || pte_ptr) begin
                        fault     = 1'b1;
                        state_nxt = S_IDLE;
                    end else begin
                        leaf      = 1'b1;
                        state_nxt = S_DONE;
                    end
                end
            end
            default:  state_nxt = S_IDLE;  // S_DONE
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && start) begin
            vaddr_q  <= vaddr;
            base_ppn <= root_ppn;
        end
        if (state == S_L1_WAIT && mem_ready && pte_ptr) begin
            base_ppn <= pte_ppn;  // Descend to level 0
        end
        if (leaf) begin
            fill_entry.vpn       <= vaddr_q[31:OFFSET_W];
            fill_entry.ppn       <= pte_ppn;
            fill_entry.u         <= mem_data.u;
            fill_entry.w         <= mem_data.w;
            fill_entry.r         <= mem_data.r;
            fill_entry.g         <= mem_data.g;
            fill_entry.superpage <= (state == S_L1_WAIT);
        end
    end

endmodule

//--- verilog/sv32_tlb.sv
module sv32_tlb #(
    parameter int TLB_ENTRIES = 8
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [31:0]             lookup_vaddr,
    output logic                    hit,
    output mmu_pkg::tlb_entry_t     hit_entry,
    input  logic                    fill,
    input  mmu_pkg::tlb_entry_t     fill_entry,
    input  logic                    flush,
    input  logic                    flush_one,
    input  logic [31:0]             flush_addr
);

    import mmu_pkg::*;

    localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

    logic                 valid [TLB_ENTRIES];
    tlb_entry_t           entries [TLB_ENTRIES];
    logic [IDX_W-1:0]     victim;  // Round-robin fill pointer

    // Superpages compare on VPN1 only
    function automatic logic vpn_match(input tlb_entry_t ent, input logic [31:0] addr);
        logic [2*VPN_W-1:0] vpn;
        vpn = addr[31:OFFSET_W];
        if (ent.superpage) begin
            return ent.vpn[2*VPN_W-1:VPN_W] == vpn[2*VPN_W-1:VPN_W];
        end
        return ent.vpn == vpn;
    endfunction

    // Walk downwards so the lowest matching slot wins
    always_comb begin
        hit       = 1'b0;
        hit_entry = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (valid[i] && vpn_match(entries[i], lookup_vaddr)) begin
                hit       = 1'b1;
                hit_entry = entries[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                valid[i] <= 1'b0;
            end
            victim <= '0;
        end else begin
            if (flush) begin
                for (int i = 0; i < TLB_ENTRIES; i++) begin
                    if (!flush_one || vpn_match(entries[i], flush_addr)) begin
                        valid[i] <= 1'b0;
                    end
                end
            end
            // Fill after flush, an in-flight walk still lands
            if (fill) begin
                valid[victim] <= 1'b1;
                if (victim == IDX_W'(TLB_ENTRIES - 1)) begin
                    victim <= '0;
                end else begin
                    victim <= victim + 1'b1;
                end
            end
        end
    end

    // Entry payload, no reset needed
    always_ff @(posedge clk) begin
        if (fill) begin
            entries[victim] <= fill_entry;
        end
    end

endmodule

//--- verilog/mmu_pkg.sv
package mmu_pkg;

    // Sv32 address split
    localparam int VPN_W    = 10;  // Per level
    localparam int PPN_W    = 20;
    localparam int OFFSET_W = 12;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_S = 2'd1,
        PRIV_M = 2'd3
    } priv_t;

    // Page table entry as stored in memory
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic        d;
        logic        a;
        logic        g;
        logic        u;
        logic        x;
        logic        w;
        logic        r;
        logic        v;
    } pte_t;

    typedef struct packed {
        logic [2*VPN_W-1:0] vpn;
        logic [PPN_W-1:0]   ppn;
        logic               u;
        logic               w;
        logic               r;
        logic               g;          // Kept, no ASID support
        logic               superpage;  // 4 MB leaf from level 1
    } tlb_entry_t;

    typedef struct packed {
        logic [31:0] vaddr;
        logic        write;
        priv_t       priv;
    } trans_req_t;

    typedef struct packed {
        logic [31:0] paddr;
        logic        done;
        logic        page_fault;
        logic        access_fault;
    } trans_rsp_t;

endpackage
